/* include/adc_rx_params.svh */
// width and count macros for the adc receive front end
`ifndef ADC_RX_PARAMS_SVH
`define ADC_RX_PARAMS_SVH

// one lane sample, a single i or q word
`define ADC_RX_IQ_W 16

// lanes per adc word, two iq pairs
`define ADC_RX_LANES 4

// full adc and baseband word width
`define ADC_RX_WORD_W (`ADC_RX_LANES * `ADC_RX_IQ_W)

// axi4-lite byte address width
`define ADC_RX_AXI_AW 4

// counter width, also the register data width
`define ADC_RX_CNT_W 32

`endif

/* src/adc_rx_pkg.sv */
// package with gain code, register map, axi response and axi fsm state types
package adc_rx_pkg;

  // power of two gain select
  // unlisted codes fall back to a shift by 4
  typedef enum logic [2:0] {
    GAIN_SH3 = 3'd3,
    GAIN_SH4 = 3'd4,
    GAIN_SH5 = 3'd5,
    GAIN_SH6 = 3'd6
  } gain_code_e;

  // register byte offsets
  typedef enum logic [3:0] {
    // gain code in bits 2:0
    REG_GAIN    = 4'h0,
    // delivered words, write clears
    REG_SAMPLES = 4'h4,
    // words with any lane overflow, write clears
    REG_OVF     = 4'h8
  } reg_addr_e;

  // axi response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // axi slave fsm
  typedef enum logic [1:0] {
    AXI_IDLE  = 2'd0,
    // write response held until bready
    AXI_WRESP = 2'd1,
    // read data held until rready
    AXI_RDATA = 2'd2
  } axi_state_e;

endpackage

/* src/adc_ctrl_regs.sv */
// axi4-lite register block with gain register, counter readback and clear strobes
`include "adc_rx_params.svh"

module adc_ctrl_regs (
  input  logic                           adc_clk,
  input  logic                           adc_rst,
  // write address and data
  input  logic [`ADC_RX_AXI_AW-1:0]      s_axi_awaddr,
  input  logic                           s_axi_awvalid,
  output logic                           s_axi_awready,
  input  logic [`ADC_RX_CNT_W-1:0]       s_axi_wdata,
  input  logic                           s_axi_wvalid,
  output logic                           s_axi_wready,
  // write response
  output adc_rx_pkg::axi_resp_e          s_axi_bresp,
  output logic                           s_axi_bvalid,
  input  logic                           s_axi_bready,
  // read address and data
  input  logic [`ADC_RX_AXI_AW-1:0]      s_axi_araddr,
  input  logic                           s_axi_arvalid,
  output logic                           s_axi_arready,
  output logic [`ADC_RX_CNT_W-1:0]       s_axi_rdata,
  output adc_rx_pkg::axi_resp_e          s_axi_rresp,
  output logic                           s_axi_rvalid,
  input  logic                           s_axi_rready,
  // counters from the output stage
  input  logic [`ADC_RX_CNT_W-1:0]       sample_count,
  input  logic [`ADC_RX_CNT_W-1:0]       ovf_count,
  // control to the datapath
  output adc_rx_pkg::gain_code_e         gain_code,
  output logic                           clr_samples,
  output logic                           clr_ovf
);
  import adc_rx_pkg::*;

  axi_state_e                 state;
  logic                       wr_accept;
  logic                       rd_accept;
  logic                       wr_hit;
  logic                       rd_hit;
  logic [`ADC_RX_CNT_W-1:0]   rd_word;
  logic [2:0]                 gain_reg;

  // write wins when both channels arrive together
  assign wr_accept = (state == AXI_IDLE) && s_axi_awvalid && s_axi_wvalid;
  assign rd_accept = (state == AXI_IDLE) && s_axi_arvalid && !wr_accept;

  assign s_axi_awready = wr_accept;
  assign s_axi_wready  = wr_accept;
  assign s_axi_arready = rd_accept;
  assign s_axi_bvalid  = (state == AXI_WRESP);
  assign s_axi_rvalid  = (state == AXI_RDATA);

  // write offset decode
  assign wr_hit = (s_axi_awaddr == REG_GAIN) || (s_axi_awaddr == REG_SAMPLES) ||
                  (s_axi_awaddr == REG_OVF);

  // clears fire in the accept cycle, data value ignored
  assign clr_samples = wr_accept && (s_axi_awaddr == REG_SAMPLES);
  assign clr_ovf     = wr_accept && (s_axi_awaddr == REG_OVF);

  assign gain_code = gain_code_e'(gain_reg);

  // read mux, unmapped offsets give zero
  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    case (s_axi_araddr)
      REG_GAIN: begin
        rd_word = {{(`ADC_RX_CNT_W-3){1'b0}}, gain_reg};
      end
      REG_SAMPLES: begin
        rd_word = sample_count;
      end
      REG_OVF: begin
        rd_word = ovf_count;
      end
      default: begin
        rd_hit = 1'b0;
      end
    endcase
  end

  // handshake fsm
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      state <= AXI_IDLE;
    end else begin
      case (state)
        AXI_IDLE: begin
          if (wr_accept) begin
            state <= AXI_WRESP;
          end else if (rd_accept) begin
            state <= AXI_RDATA;
          end
        end
        AXI_WRESP: begin
          if (s_axi_bready) begin
            state <= AXI_IDLE;
          end
        end
        AXI_RDATA: begin
          if (s_axi_rready) begin
            state <= AXI_IDLE;
          end
        end
        default: begin
          state <= AXI_IDLE;
        end
      endcase
    end
  end

  // gain register, only a mapped write to offset 0 changes it
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      gain_reg <= 3'd0;
    end else if (wr_accept && (s_axi_awaddr == REG_GAIN)) begin
      gain_reg <= s_axi_wdata[2:0];
    end
  end

  // response payload, captured at accept and held
  always_ff @(posedge adc_clk) begin
    if (wr_accept) begin
      s_axi_bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_accept) begin
      s_axi_rdata <= rd_word;
      s_axi_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

/* src/adc_decimator.sv */
// decimate-by-2 of the adc word stream and split into lane samples
`include "adc_rx_params.svh"

module adc_decimator (
  input  logic                        adc_clk,
  input  logic                        adc_rst,
  input  logic [`ADC_RX_WORD_W-1:0]   adc_data,
  input  logic                        adc_data_valid,
  output logic [`ADC_RX_IQ_W-1:0]     lane_sample [`ADC_RX_LANES],
  output logic                        lane_valid
);

  // 0 means the next valid word is kept
  logic                       phase;
  logic                       keep_now;
  // input capture stage
  logic                       keep_q;
  logic [`ADC_RX_WORD_W-1:0]  word_q;

  assign keep_now = adc_data_valid && !phase;

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      phase      <= 1'b0;
      keep_q     <= 1'b0;
      lane_valid <= 1'b0;
    end else begin
      // toggles on every valid word, kept or not
      if (adc_data_valid) begin
        phase <= ~phase;
      end
      keep_q     <= keep_now;
      lane_valid <= keep_q;
    end
  end

  // capture the kept word
  always_ff @(posedge adc_clk) begin
    if (keep_now) begin
      word_q <= adc_data;
    end
  end

  // lane k sits at bits k*IQ_W upward
  always_ff @(posedge adc_clk) begin
    if (keep_q) begin
      for (int k = 0; k < `ADC_RX_LANES; k++) begin
        lane_sample[k] <= word_q[k*`ADC_RX_IQ_W +: `ADC_RX_IQ_W];
      end
    end
  end

endmodule

/* src/gain_shift_lane.sv */
// one lane of power-of-two gain by left shift, with overflow flag
`include "adc_rx_params.svh"

module gain_shift_lane #(
  parameter int IQ_W = `ADC_RX_IQ_W
) (
  input  logic                    adc_clk,
  input  logic                    adc_rst,
  input  logic [IQ_W-1:0]         sample,
  input  logic                    sample_valid,
  input  adc_rx_pkg::gain_code_e  gain_code,
  output logic [IQ_W-1:0]         shifted,
  output logic                    ovf,
  output logic                    shifted_valid
);
  import adc_rx_pkg::*;

  logic [2:0]       shift_amt;
  logic [IQ_W-1:0]  shifted_next;
  logic             ovf_next;

  // code to shift amount, anything unlisted shifts by 4
  always_comb begin
    case (gain_code)
      GAIN_SH3: shift_amt = 3'd3;
      GAIN_SH4: shift_amt = 3'd4;
      GAIN_SH5: shift_amt = 3'd5;
      GAIN_SH6: shift_amt = 3'd6;
      default:  shift_amt = 3'd4;
    endcase
  end

  // zero fill from the bottom
  // overflow when a dropped bit or the new sign bit differs from the old sign
  always_comb begin
    shifted_next = sample << shift_amt;
    ovf_next     = 1'b0;
    for (int i = 0; i < IQ_W - 1; i++) begin
      if ((i >= IQ_W - 1 - int'(shift_amt)) && (sample[i] != sample[IQ_W-1])) begin
        ovf_next = 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      shifted_valid <= 1'b0;
    end else begin
      shifted_valid <= sample_valid;
    end
  end

  // result holds between valid samples
  always_ff @(posedge adc_clk) begin
    if (sample_valid) begin
      shifted <= shifted_next;
      ovf     <= ovf_next;
    end
  end

endmodule

/* src/bb_output_stage.sv */
// baseband word packing, valid pulse, and delivered and overflow word counters
`include "adc_rx_params.svh"

module bb_output_stage (
  input  logic                        adc_clk,
  input  logic                        adc_rst,
  input  logic [`ADC_RX_IQ_W-1:0]     shifted [`ADC_RX_LANES],
  input  logic [`ADC_RX_LANES-1:0]    ovf,
  input  logic                        shifted_valid,
  input  logic                        clr_samples,
  input  logic                        clr_ovf,
  output logic [`ADC_RX_WORD_W-1:0]   data_to_bb,
  output logic                        data_to_bb_valid,
  output logic [`ADC_RX_CNT_W-1:0]    sample_count,
  output logic [`ADC_RX_CNT_W-1:0]    ovf_count
);

  // any lane lost bits in this word
  logic word_ovf;

  assign word_ovf = |ovf;

  // pack lanes back into the word, lane 0 lowest
  always_ff @(posedge adc_clk) begin
    if (shifted_valid) begin
      for (int k = 0; k < `ADC_RX_LANES; k++) begin
        data_to_bb[k*`ADC_RX_IQ_W +: `ADC_RX_IQ_W] <= shifted[k];
      end
    end
  end

  // single cycle valid per word
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      data_to_bb_valid <= 1'b0;
    end else begin
      data_to_bb_valid <= shifted_valid;
    end
  end

  // delivered words, clear beats increment
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      sample_count <= '0;
    end else if (clr_samples) begin
      sample_count <= '0;
    end else if (shifted_valid) begin
      // wraps at full width
      sample_count <= sample_count + 1'b1;
    end
  end

  // words with at least one overflowed lane
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      ovf_count <= '0;
    end else if (clr_ovf) begin
      ovf_count <= '0;
    end else if (shifted_valid && word_ovf) begin
      ovf_count <= ovf_count + 1'b1;
    end
  end

endmodule

/* src/adc_rx_top.sv */
// top level of the adc receive front end, regs, decimator, gain lanes and output stage
`include "adc_rx_params.svh"

module adc_rx_top (
  input  logic                        adc_clk,
  input  logic                        adc_rst,
  // adc sample stream
  input  logic [`ADC_RX_WORD_W-1:0]   adc_data,
  input  logic                        adc_data_valid,
  // axi4-lite slave
  input  logic [`ADC_RX_AXI_AW-1:0]   s_axi_awaddr,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [`ADC_RX_CNT_W-1:0]    s_axi_wdata,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  output adc_rx_pkg::axi_resp_e       s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  input  logic [`ADC_RX_AXI_AW-1:0]   s_axi_araddr,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  output logic [`ADC_RX_CNT_W-1:0]    s_axi_rdata,
  output adc_rx_pkg::axi_resp_e       s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,
  // baseband stream
  output logic [`ADC_RX_WORD_W-1:0]   data_to_bb,
  output logic                        data_to_bb_valid
);
  import adc_rx_pkg::*;

  gain_code_e                   gain_code;
  logic                         clr_samples;
  logic                         clr_ovf;
  logic [`ADC_RX_CNT_W-1:0]     sample_count;
  logic [`ADC_RX_CNT_W-1:0]     ovf_count;
  logic [`ADC_RX_IQ_W-1:0]      lane_sample [`ADC_RX_LANES];
  logic                         lane_valid;
  logic [`ADC_RX_IQ_W-1:0]      shifted [`ADC_RX_LANES];
  logic [`ADC_RX_LANES-1:0]     ovf;
  // per lane valids, all in lockstep
  logic [`ADC_RX_LANES-1:0]     lane_out_valid;
  logic                         shifted_valid;

  assign shifted_valid = &lane_out_valid;

  adc_ctrl_regs regs0 (
    .adc_clk       (adc_clk),
    .adc_rst       (adc_rst),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .sample_count  (sample_count),
    .ovf_count     (ovf_count),
    .gain_code     (gain_code),
    .clr_samples   (clr_samples),
    .clr_ovf       (clr_ovf)
  );

  adc_decimator dec0 (
    .adc_clk        (adc_clk),
    .adc_rst        (adc_rst),
    .adc_data       (adc_data),
    .adc_data_valid (adc_data_valid),
    .lane_sample    (lane_sample),
    .lane_valid     (lane_valid)
  );

  // one gain lane per iq word
  for (genvar k = 0; k < `ADC_RX_LANES; k++) begin : g_lane
    gain_shift_lane #(
      .IQ_W (`ADC_RX_IQ_W)
    ) lane0 (
      .adc_clk       (adc_clk),
      .adc_rst       (adc_rst),
      .sample        (lane_sample[k]),
      .sample_valid  (lane_valid),
      .gain_code     (gain_code),
      .shifted       (shifted[k]),
      .ovf           (ovf[k]),
      .shifted_valid (lane_out_valid[k])
    );
  end

  bb_output_stage out0 (
    .adc_clk          (adc_clk),
    .adc_rst          (adc_rst),
    .shifted          (shifted),
    .ovf              (ovf),
    .shifted_valid    (shifted_valid),
    .clr_samples      (clr_samples),
    .clr_ovf          (clr_ovf),
    .data_to_bb       (data_to_bb),
    .data_to_bb_valid (data_to_bb_valid),
    .sample_count     (sample_count),
    .ovf_count        (ovf_count)
  );

endmodule

/* verification/adc_rx_tb.sv */
// testbench for adc_rx_top with random stream, reference model, axi tasks and typed compares
`include "adc_rx_params.svh"

module adc_rx_tb;
  import adc_rx_pkg::*;

  localparam int AXI_TIMEOUT   = 20;
  localparam int DRAIN_TIMEOUT = 16;
  localparam int W             = `ADC_RX_IQ_W;

  logic                        adc_clk;
  logic                        adc_rst;
  logic [`ADC_RX_WORD_W-1:0]   adc_data;
  logic                        adc_data_valid;
  logic [`ADC_RX_AXI_AW-1:0]   s_axi_awaddr;
  logic                        s_axi_awvalid;
  logic                        s_axi_awready;
  logic [`ADC_RX_CNT_W-1:0]    s_axi_wdata;
  logic                        s_axi_wvalid;
  logic                        s_axi_wready;
  axi_resp_e                   s_axi_bresp;
  logic                        s_axi_bvalid;
  logic                        s_axi_bready;
  logic [`ADC_RX_AXI_AW-1:0]   s_axi_araddr;
  logic                        s_axi_arvalid;
  logic                        s_axi_arready;
  logic [`ADC_RX_CNT_W-1:0]    s_axi_rdata;
  axi_resp_e                   s_axi_rresp;
  logic                        s_axi_rvalid;
  logic                        s_axi_rready;
  logic [`ADC_RX_WORD_W-1:0]   data_to_bb;
  logic                        data_to_bb_valid;

  integer                      seed;
  // cycle stamp, counts rising edges since reset release
  int                          cyc;
  // reference model state
  logic                        model_phase;
  logic [2:0]                  model_gain;
  logic [`ADC_RX_CNT_W-1:0]    model_samples;
  logic [`ADC_RX_CNT_W-1:0]    model_ovf;
  logic [`ADC_RX_WORD_W-1:0]   exp_q [$];
  int                          stamp_q [$];
  bit                          ovf_q [$];

  adc_rx_top dut0 (
    .adc_clk          (adc_clk),
    .adc_rst          (adc_rst),
    .adc_data         (adc_data),
    .adc_data_valid   (adc_data_valid),
    .s_axi_awaddr     (s_axi_awaddr),
    .s_axi_awvalid    (s_axi_awvalid),
    .s_axi_awready    (s_axi_awready),
    .s_axi_wdata      (s_axi_wdata),
    .s_axi_wvalid     (s_axi_wvalid),
    .s_axi_wready     (s_axi_wready),
    .s_axi_bresp      (s_axi_bresp),
    .s_axi_bvalid     (s_axi_bvalid),
    .s_axi_bready     (s_axi_bready),
    .s_axi_araddr     (s_axi_araddr),
    .s_axi_arvalid    (s_axi_arvalid),
    .s_axi_arready    (s_axi_arready),
    .s_axi_rdata      (s_axi_rdata),
    .s_axi_rresp      (s_axi_rresp),
    .s_axi_rvalid     (s_axi_rvalid),
    .s_axi_rready     (s_axi_rready),
    .data_to_bb       (data_to_bb),
    .data_to_bb_valid (data_to_bb_valid)
  );

  initial adc_clk = 1'b0;
  always #2 adc_clk = ~adc_clk;

  task automatic stop_sim();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`ADC_RX_WORD_W-1:0] exp,
                            input logic [`ADC_RX_WORD_W-1:0] act);
    if (exp !== act) begin
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_sim();
    end
  endtask

  task automatic check_count(input string name, input logic [`ADC_RX_CNT_W-1:0] exp,
                             input logic [`ADC_RX_CNT_W-1:0] act);
    if (exp !== act) begin
      $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, act);
      stop_sim();
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (exp !== act) begin
      $display("ERROR t=%0t %s expected %s got %s (%b)", $time, name, exp.name(), act.name(),
               act);
      stop_sim();
    end
  endtask

  // gain rule, codes 3 to 6 shift by their value, the rest by 4
  function automatic int gain_shift(input logic [2:0] code);
    return ((code >= 3'd3) && (code <= 3'd6)) ? int'(code) : 4;
  endfunction

  // zero fill left shift per lane
  function automatic logic [`ADC_RX_WORD_W-1:0] model_word(
      input logic [`ADC_RX_WORD_W-1:0] word, input logic [2:0] code);
    logic [`ADC_RX_WORD_W-1:0] res;
    logic [W-1:0]              lane;
    for (int k = 0; k < `ADC_RX_LANES; k++) begin
      lane = word[k*W +: W];
      res[k*W +: W] = lane << gain_shift(code);
    end
    return res;
  endfunction

  // a lane overflows when shifting back does not restore the signed value
  function automatic bit word_overflows(input logic [`ADC_RX_WORD_W-1:0] word,
                                        input logic [2:0] code);
    logic signed [W-1:0] lane;
    logic signed [W-1:0] grown;
    bit                  any;
    any = 1'b0;
    for (int k = 0; k < `ADC_RX_LANES; k++) begin
      lane  = word[k*W +: W];
      grown = lane <<< gain_shift(code);
      if ((grown >>> gain_shift(code)) != lane) begin
        any = 1'b1;
      end
    end
    return any;
  endfunction

  // intake side of the model, every second valid word from reset on
  always @(posedge adc_clk) begin
    if (adc_rst) begin
      cyc = 0;
      model_phase = 1'b0;
    end else begin
      cyc = cyc + 1;
      if (adc_data_valid) begin
        if (!model_phase) begin
          exp_q.push_back(model_word(adc_data, model_gain));
          ovf_q.push_back(word_overflows(adc_data, model_gain));
          stamp_q.push_back(cyc);
        end
        model_phase = ~model_phase;
      end
    end
  end

  // output monitor, sampled mid cycle
  always @(negedge adc_clk) begin
    if (!adc_rst && data_to_bb_valid) begin
      if (exp_q.size() == 0) begin
        $display("data_to_bb_valid pulsed while the model expected no word");
        stop_sim();
      end else begin
        check_word("data_to_bb", exp_q.pop_front(), data_to_bb);
        check_count("data_to_bb latency", 3, cyc - stamp_q.pop_front());
        model_samples = model_samples + 1'b1;
        if (ovf_q.pop_front()) begin
          model_ovf = model_ovf + 1'b1;
        end
      end
    end
  end

  task automatic write_reg(input logic [`ADC_RX_AXI_AW-1:0] addr,
                           input logic [`ADC_RX_CNT_W-1:0] data, output axi_resp_e resp);
    int n;
    @(negedge adc_clk);
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wvalid  = 1'b1;
    n = 0;
    // ready lines are combinational, look at them while the clock is low
    #1;
    while (!(s_axi_awready && s_axi_wready) && n < AXI_TIMEOUT) begin
      @(negedge adc_clk);
      #1;
      n++;
    end
    if (!(s_axi_awready && s_axi_wready)) begin
      $display("write to offset %h was never accepted, awready and wready stayed low", addr);
      stop_sim();
    end
    @(negedge adc_clk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    // bvalid follows the accept cycle directly
    if (!s_axi_bvalid) begin
      $display("no write response came the cycle after offset %h was accepted", addr);
      stop_sim();
    end
    resp         = s_axi_bresp;
    s_axi_bready = 1'b1;
    n = 0;
    @(negedge adc_clk);
    while (s_axi_bvalid && n < AXI_TIMEOUT) begin
      @(negedge adc_clk);
      n++;
    end
    if (s_axi_bvalid) begin
      $display("write response for offset %h stayed valid after bready", addr);
      stop_sim();
    end
    s_axi_bready = 1'b0;
  endtask

  task automatic read_reg(input logic [`ADC_RX_AXI_AW-1:0] addr,
                          output logic [`ADC_RX_CNT_W-1:0] data, output axi_resp_e resp);
    int n;
    @(negedge adc_clk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    n = 0;
    #1;
    while (!s_axi_arready && n < AXI_TIMEOUT) begin
      @(negedge adc_clk);
      #1;
      n++;
    end
    if (!s_axi_arready) begin
      $display("read from offset %h was never accepted, arready stayed low", addr);
      stop_sim();
    end
    @(negedge adc_clk);
    s_axi_arvalid = 1'b0;
    // rvalid follows the accept cycle directly
    if (!s_axi_rvalid) begin
      $display("no read data came the cycle after offset %h was accepted", addr);
      stop_sim();
    end
    data         = s_axi_rdata;
    resp         = s_axi_rresp;
    s_axi_rready = 1'b1;
    n = 0;
    @(negedge adc_clk);
    while (s_axi_rvalid && n < AXI_TIMEOUT) begin
      @(negedge adc_clk);
      n++;
    end
    if (s_axi_rvalid) begin
      $display("read data for offset %h stayed valid after rready", addr);
      stop_sim();
    end
    s_axi_rready = 1'b0;
  endtask

  task automatic poke_reg(input string name, input logic [`ADC_RX_AXI_AW-1:0] addr,
                          input logic [`ADC_RX_CNT_W-1:0] data, input axi_resp_e exp_resp);
    axi_resp_e resp;
    write_reg(addr, data, resp);
    check_resp({name, " bresp"}, exp_resp, resp);
  endtask

  task automatic probe_reg(input string name, input logic [`ADC_RX_AXI_AW-1:0] addr,
                           input logic [`ADC_RX_CNT_W-1:0] exp_data, input axi_resp_e exp_resp);
    axi_resp_e                resp;
    logic [`ADC_RX_CNT_W-1:0] data;
    read_reg(addr, data, resp);
    check_resp({name, " rresp"}, exp_resp, resp);
    check_count({name, " rdata"}, exp_data, data);
  endtask

  task automatic clear_counters();
    poke_reg("samples clear", REG_SAMPLES, 32'hffff_ffff, RESP_OKAY);
    model_samples = '0;
    poke_reg("ovf clear", REG_OVF, 32'h0, RESP_OKAY);
    model_ovf = '0;
    probe_reg("samples after clear", REG_SAMPLES, 0, RESP_OKAY);
    probe_reg("ovf after clear", REG_OVF, 0, RESP_OKAY);
  endtask

  // random words with random valid gaps, then wait for the pipe to empty
  task automatic run_stream(input int n_cycles, input bit full_scale);
    int           n;
    logic [W-1:0] lane;
    for (int i = 0; i < n_cycles; i++) begin
      @(negedge adc_clk);
      adc_data_valid = (($random(seed) & 3) != 0);
      for (int k = 0; k < `ADC_RX_LANES; k++) begin
        lane = $random(seed);
        if (full_scale) begin
          // bias toward the two rails
          case ($random(seed) & 3)
            0: lane = 16'h7fff;
            1: lane = 16'h8000;
            default: ;
          endcase
        end
        adc_data[k*W +: W] = lane;
      end
    end
    @(negedge adc_clk);
    adc_data_valid = 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      @(negedge adc_clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("kept words never reached data_to_bb, %0d still pending", exp_q.size());
      stop_sim();
    end
  endtask

  initial begin
    seed           = 32'h562d0435;
    adc_rst        = 1'b1;
    adc_data       = '0;
    adc_data_valid = 1'b0;
    s_axi_awaddr   = '0;
    s_axi_awvalid  = 1'b0;
    s_axi_wdata    = '0;
    s_axi_wvalid   = 1'b0;
    s_axi_bready   = 1'b0;
    s_axi_araddr   = '0;
    s_axi_arvalid  = 1'b0;
    s_axi_rready   = 1'b0;
    model_gain     = 3'd0;
    model_samples  = '0;
    model_ovf      = '0;
    repeat (5) @(posedge adc_clk);
    @(negedge adc_clk);
    adc_rst = 1'b0;

    // reset values
    probe_reg("gain after reset", REG_GAIN, 0, RESP_OKAY);
    probe_reg("samples after reset", REG_SAMPLES, 0, RESP_OKAY);
    probe_reg("ovf after reset", REG_OVF, 0, RESP_OKAY);

    // decimation under the default gain
    run_stream(200, 1'b0);
    probe_reg("sample count", REG_SAMPLES, model_samples, RESP_OKAY);
    probe_reg("ovf count", REG_OVF, model_ovf, RESP_OKAY);

    // every gain code, stream idle while writing
    for (int code = 0; code < 8; code++) begin
      poke_reg("gain write", REG_GAIN, code, RESP_OKAY);
      model_gain = code;
      probe_reg("gain readback", REG_GAIN, code, RESP_OKAY);
      run_stream(24, 1'b0);
    end

    // overflow counting at the largest gain
    clear_counters();
    poke_reg("gain write", REG_GAIN, GAIN_SH6, RESP_OKAY);
    model_gain = 3'd6;
    run_stream(150, 1'b1);
    probe_reg("ovf count at gain 6", REG_OVF, model_ovf, RESP_OKAY);
    probe_reg("sample count at gain 6", REG_SAMPLES, model_samples, RESP_OKAY);

    // clear, then both counters climb again
    clear_counters();
    run_stream(40, 1'b1);
    probe_reg("sample count after clear", REG_SAMPLES, model_samples, RESP_OKAY);
    probe_reg("ovf count after clear", REG_OVF, model_ovf, RESP_OKAY);

    // unmapped offsets
    poke_reg("unmapped write", 4'hc, 32'h3, RESP_SLVERR);
    probe_reg("gain after unmapped write", REG_GAIN, 6, RESP_OKAY);
    probe_reg("unmapped read 0xc", 4'hc, 0, RESP_SLVERR);
    probe_reg("unmapped read 0x2", 4'h2, 0, RESP_SLVERR);

    if (exp_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("model still holds %0d undelivered words at the end", exp_q.size());
      stop_sim();
    end
  end

endmodule

/* filelist.f */
+incdir+include
src/adc_rx_pkg.sv
src/adc_ctrl_regs.sv
src/adc_decimator.sv
src/gain_shift_lane.sv
src/bb_output_stage.sv
src/adc_rx_top.sv
verification/adc_rx_tb.sv

/* Bender.yml */
package:
  name: adc_rx

export_include_dirs:
  - include

sources:
  - src/adc_rx_pkg.sv
  - src/adc_ctrl_regs.sv
  - src/adc_decimator.sv
  - src/gain_shift_lane.sv
  - src/bb_output_stage.sv
  - src/adc_rx_top.sv
  - target: test
    files:
      - verification/adc_rx_tb.sv
